/* verilog.f */
verilog/pma_pkg.sv
verilog/pma_region_table.sv
verilog/pma_lookup_arbiter.sv
verilog/pma_access_checker.sv
verilog/pma_unit_top.sv
test/tb_pma_unit.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the pma unit testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --assert -f verilog.f --top-module tb_pma_unit \
	-o tb_pma_unit_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "compile failed"
	exit 1
fi

./obj_dir/tb_pma_unit_sim > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$SIM_LOG"
	echo "simulation exited with an error"
	exit 1
fi

cat "$SIM_LOG"
if grep -qx "NO ERRORS" "$SIM_LOG"; then
	exit 0
fi
exit 1

/* test/tb_pma_unit.sv */
`default_nettype none

module tb_pma_unit;

	// ============================================================
	// dut signals
	// ============================================================
	logic                              clk;
	logic                              rst_n;
	logic                              cfg_cs, cfg_we;
	logic [8:0]                        cfg_addr;
	logic [pma_pkg::cfg_data_bits-1:0] cfg_wdata, cfg_rdata;
	logic                              if_req, if_busy, if_done, if_cacheable;
	logic [pma_pkg::addr_bits-1:0]     if_addr;
	logic [1:0]                        if_pl;
	logic [7:0]                        if_dev_type;
	pma_pkg::fault_e                   if_fault;
	logic                              dc_req, dc_busy, dc_done, dc_cacheable;
	logic [pma_pkg::addr_bits-1:0]     dc_addr;
	logic [1:0]                        dc_pl;
	logic [7:0]                        dc_dev_type;
	pma_pkg::access_e                  dc_acc;
	pma_pkg::fault_e                   dc_fault;

	int          checks = 0;
	int          mismatches = 0;
	int          failures = 0;          // timeouts and protocol slips
	logic [31:0] lcg_state = 32'd64;    // seed

	// model of the region table
	logic [31:0] m_pmt  [8];
	logic [31:0] m_cta  [8];
	logic [63:0] m_at   [8];
	logic [31:0] m_lock [8];

	pma_unit_top dut (
		.clk (clk), .rst_n (rst_n),
		.cfg_cs (cfg_cs), .cfg_we (cfg_we), .cfg_addr (cfg_addr),
		.cfg_wdata (cfg_wdata), .cfg_rdata (cfg_rdata),
		.if_req (if_req), .if_addr (if_addr), .if_pl (if_pl), .if_busy (if_busy),
		.if_done (if_done), .if_fault (if_fault), .if_cacheable (if_cacheable),
		.if_dev_type (if_dev_type),
		.dc_req (dc_req), .dc_addr (dc_addr), .dc_pl (dc_pl), .dc_acc (dc_acc),
		.dc_busy (dc_busy), .dc_done (dc_done), .dc_fault (dc_fault),
		.dc_cacheable (dc_cacheable), .dc_dev_type (dc_dev_type)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;   // period 20
	end

	// ============================================================
	// reference model
	// ============================================================
	function automatic logic [63:0] map_attr(input int r);
		logic [3:0] rwx;
		logic [7:0] dev;
		rwx = 4'h0;
		dev = 8'h00;
		case (r)
		7:       rwx = 4'hD;       // rom
		5, 6:    rwx = 4'h6;       // config space and io
		4:       rwx = 4'hF;       // scratchpad
		1: begin                   // dram
			rwx = 4'hF;
			dev = 8'h01;
		end
		default: dev = 8'hFF;      // vacant
		endcase
		map_attr = {4{dev, 4'h0, rwx}};
	endfunction

	function automatic logic [31:0] map_pmt(input int r);
		case (r)
		6:       map_pmt = 32'h0000_0300;
		4:       map_pmt = 32'h0000_2300;
		1:       map_pmt = 32'h0000_2400;
		default: map_pmt = 32'h0;
		endcase
	endfunction

	function automatic logic [63:0] model_word(input logic [2:0] r, input logic [1:0] f);
		case (f)
		2'd0:    model_word = {32'h0, m_pmt[r]};
		2'd1:    model_word = {32'h0, m_cta[r]};
		2'd2:    model_word = m_at[r];
		default: model_word = {32'h0, m_lock[r]};
		endcase
	endfunction

	// entry picked by pl from the region in the top address bits
	function automatic logic [15:0] model_entry(input logic [31:0] a, input logic [1:0] pl);
		model_entry = m_at[a[31:29]][pl*16 +: 16];
	endfunction

	function automatic pma_pkg::fault_e model_fault(input logic [15:0] e,
			input pma_pkg::access_e ac);
		model_fault = pma_pkg::FAULT_NONE;
		if (e[15:8] == 8'hFF)
			model_fault = pma_pkg::FAULT_NO_ACCESS;   // vacant first
		else if (ac == pma_pkg::ACC_READ && !e[2])
			model_fault = pma_pkg::FAULT_NO_READ;
		else if (ac == pma_pkg::ACC_WRITE && !e[1])
			model_fault = pma_pkg::FAULT_NO_WRITE;
		else if (ac == pma_pkg::ACC_EXEC && !e[0])
			model_fault = pma_pkg::FAULT_NO_EXEC;
	endfunction

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		next_rand = lcg_state ^ (lcg_state >> 16);   // fold high bits down
	endfunction

	// ============================================================
	// checks and bus tasks
	// ============================================================
	task automatic report_mismatch(input string name, input logic [63:0] exp,
			input logic [63:0] act);
		mismatches++;
		$display("Mismatch at time %0t: %s expected %0h got %0h", $time, name, exp, act);
	endtask

	task automatic report_failure(input string what);
		failures++;
		$display("time %0t: %s", $time, what);
	endtask

	task automatic check_value(input string name, input logic [63:0] exp,
			input logic [63:0] act);
		checks++;
		assert (act === exp) else report_mismatch(name, exp, act);
	endtask

	task automatic cfg_write(input logic [2:0] r, input logic [1:0] f, input logic [63:0] d);
		@(posedge clk);
		cfg_cs    <= 1'b1;
		cfg_we    <= 1'b1;
		cfg_addr  <= {r, f, 4'h0};
		cfg_wdata <= d;
		@(posedge clk);            // write lands here
		cfg_cs <= 1'b0;
		cfg_we <= 1'b0;
		if (f == 2'd3)
			m_lock[r] = d[31:0];   // lock word always open
		else if (m_lock[r] == pma_pkg::unlock_word) begin
			if (f == 2'd0)
				m_pmt[r] = d[31:0];
			else if (f == 2'd1)
				m_cta[r] = d[31:0];
			else
				m_at[r] = d;
		end
	endtask

	task automatic cfg_read_check(input logic [2:0] r, input logic [1:0] f);
		logic [63:0] exp;
		exp = model_word(r, f);
		@(posedge clk);
		cfg_cs   <= 1'b1;
		cfg_we   <= 1'b0;
		cfg_addr <= {r, f, 4'h0};
		@(posedge clk);            // rdata registered here
		cfg_cs <= 1'b0;
		@(negedge clk);
		check_value("cfg_rdata", exp, cfg_rdata);
	endtask

	// one fetch and/or data access with req held through busy when hold is set
	task automatic run_access(input logic if_en, input logic [31:0] if_a,
			input logic [1:0] if_p, input logic dc_en, input logic [31:0] dc_a,
			input logic [1:0] dc_p, input pma_pkg::access_e dc_ac, input logic hold);
		logic [15:0]     if_e, dc_e;
		pma_pkg::fault_e if_f, dc_f;
		logic            if_pend, dc_pend;
		int              cyc, if_cyc, dc_cyc;
		if_e    = model_entry(if_a, if_p);
		dc_e    = model_entry(dc_a, dc_p);
		if_f    = model_fault(if_e, pma_pkg::ACC_EXEC);
		dc_f    = model_fault(dc_e, dc_ac);
		if_pend = if_en;
		dc_pend = dc_en;
		cyc     = 0;
		if_cyc  = 0;
		dc_cyc  = 0;
		@(posedge clk);
		if_req  <= if_en;
		if_addr <= if_a;
		if_pl   <= if_p;
		dc_req  <= dc_en;
		dc_addr <= dc_a;
		dc_pl   <= dc_p;
		dc_acc  <= dc_ac;
		@(posedge clk);            // accept edge
		if_req  <= if_en & hold;   // lands while busy and must be dropped
		dc_req  <= dc_en & hold;
		if_addr <= ~if_a;          // other region that is never captured
		if_pl   <= ~if_p;
		dc_addr <= ~dc_a;
		dc_pl   <= ~dc_p;
		while ((if_pend || dc_pend) && cyc < 20) begin
			@(negedge clk);
			cyc++;
			if (if_done) begin
				if (if_pend) begin
					if_pend = 1'b0;
					if_cyc  = cyc;
					check_value("if_fault", 64'(if_f), 64'(if_fault));
					check_value("if_cacheable", 64'(if_e[3]), 64'(if_cacheable));
					check_value("if_dev_type", 64'(if_e[15:8]), 64'(if_dev_type));
				end else
					report_failure("fetch done seen with no fetch pending");
			end
			if (dc_done) begin
				if (dc_pend) begin
					dc_pend = 1'b0;
					dc_cyc  = cyc;
					check_value("dc_fault", 64'(dc_f), 64'(dc_fault));
					check_value("dc_cacheable", 64'(dc_e[3]), 64'(dc_cacheable));
					check_value("dc_dev_type", 64'(dc_e[15:8]), 64'(dc_dev_type));
				end else
					report_failure("data done seen with no data access pending");
			end
			@(posedge clk);
			if (!if_pend)
				if_req <= 1'b0;    // last held edge falls in ST_DONE
			if (!dc_pend)
				dc_req <= 1'b0;
		end
		if (if_pend)
			report_failure("fetch checker timed out waiting for done");
		if (dc_pend)
			report_failure("data checker timed out waiting for done");
		if (if_en && dc_en) begin
			assert (if_cyc <= 3 && dc_cyc <= 3 && if_cyc != dc_cyc)
				else report_failure("contended checks too slow or done on the same cycle");
		end else if (if_en)
			check_value("if_latency", 64'(2), 64'(if_cyc));
		else
			check_value("dc_latency", 64'(2), 64'(dc_cyc));
		@(negedge clk);            // both idle with no second accept
		check_value("if_busy", 64'(0), 64'(if_busy));
		check_value("dc_busy", 64'(0), 64'(dc_busy));
	endtask

	// ============================================================
	// stimulus
	// ============================================================
	initial begin
		logic [31:0] rnd;
		logic [1:0]  acc_bits;
		rst_n     <= 1'b0;
		cfg_cs    <= 1'b0;
		cfg_we    <= 1'b0;
		cfg_addr  <= '0;
		cfg_wdata <= '0;
		if_req    <= 1'b0;
		if_addr   <= '0;
		if_pl     <= 2'd0;
		dc_req    <= 1'b0;
		dc_addr   <= '0;
		dc_pl     <= 2'd0;
		dc_acc    <= pma_pkg::ACC_READ;
		for (int r = 0; r < 8; r++) begin
			m_pmt[r]  = map_pmt(r);
			m_cta[r]  = 32'h0;
			m_at[r]   = map_attr(r);
			m_lock[r] = pma_pkg::lock_word;   // all regions start locked
		end
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value("if_busy", 64'(0), 64'(if_busy));
		check_value("dc_busy", 64'(0), 64'(dc_busy));
		check_value("if_done", 64'(0), 64'(if_done));
		check_value("dc_done", 64'(0), 64'(dc_done));
		check_value("lk_req", 64'(0), 64'({dut.if_lk_req, dut.dc_lk_req}));
		check_value("lk_gnt", 64'(0), 64'({dut.if_lk_gnt, dut.dc_lk_gnt}));
		check_value("cfg_rdata", 64'(0), cfg_rdata);

		// reset contents through both checkers at pl 0
		for (int r = 0; r < 8; r++) begin
			run_access(1'b1, {3'(r), 29'h0f00}, 2'd0, 1'b0, 32'h0, 2'd0,
				pma_pkg::ACC_READ, 1'b0);
			run_access(1'b0, 32'h0, 2'd0, 1'b1, {3'(r), 29'h0040}, 2'd0,
				pma_pkg::ACC_READ, 1'b0);
			run_access(1'b0, 32'h0, 2'd0, 1'b1, {3'(r), 29'h0080}, 2'd0,
				pma_pkg::ACC_WRITE, 1'b0);
		end

		// config readback of every field
		for (int r = 0; r < 8; r++)
			for (int f = 0; f < 4; f++)
				cfg_read_check(3'(r), 2'(f));
		@(negedge clk);            // a cycle with no strobe
		check_value("cfg_rdata idle", 64'(0), cfg_rdata);

		// lock rule on the scratchpad
		cfg_write(3'd4, 2'd2, 64'h0);                      // ignored while locked
		cfg_write(3'd4, 2'd1, 64'h0000_0000_0000_5000);    // ignored too
		cfg_read_check(3'd4, 2'd2);
		cfg_read_check(3'd4, 2'd1);
		run_access(1'b0, 32'h0, 2'd0, 1'b1, 32'h8000_0010, 2'd0, pma_pkg::ACC_WRITE, 1'b0);
		cfg_write(3'd4, 2'd3, {32'h0, pma_pkg::unlock_word});
		cfg_write(3'd4, 2'd2, {4{8'h02, 4'h0, 4'h4}});    // read only now
		cfg_write(3'd4, 2'd0, 64'hFFFF_FFFF_0000_2380);   // upper half dropped
		cfg_write(3'd4, 2'd1, 64'h1234_5678_0000_5000);
		cfg_read_check(3'd4, 2'd3);
		cfg_read_check(3'd4, 2'd2);
		cfg_read_check(3'd4, 2'd0);
		cfg_read_check(3'd4, 2'd1);
		run_access(1'b0, 32'h0, 2'd0, 1'b1, 32'h8000_0010, 2'd2, pma_pkg::ACC_WRITE, 1'b0);
		cfg_write(3'd4, 2'd3, {32'h0, pma_pkg::lock_word});
		cfg_write(3'd4, 2'd2, 64'hFFFF_FFFF_FFFF_FFFF);   // blocked again
		cfg_read_check(3'd4, 2'd2);

		// both checkers on the same edge
		run_access(1'b1, 32'h2000_0040, 2'd0, 1'b1, 32'hE000_0000, 2'd0,
			pma_pkg::ACC_WRITE, 1'b0);
		run_access(1'b1, 32'hE000_0100, 2'd3, 1'b1, 32'hA000_0000, 2'd1,
			pma_pkg::ACC_READ, 1'b0);
		run_access(1'b1, 32'h0000_0000, 2'd0, 1'b1, 32'h2000_0000, 2'd2,
			pma_pkg::ACC_EXEC, 1'b1);

		// random traffic mixed with unlocks and attribute writes
		for (int i = 0; i < 200; i++) begin
			rnd = next_rand();
			if (rnd[3:0] == 4'd0) begin
				cfg_write(rnd[6:4], 2'd3,
					{32'h0, rnd[7] ? pma_pkg::lock_word : pma_pkg::unlock_word});
				cfg_write(rnd[10:8], 2'd2, {next_rand(), next_rand()});
				cfg_read_check(rnd[10:8], 2'd2);
			end else begin
				acc_bits = (rnd[9:8] == 2'd3) ? 2'd0 : rnd[9:8];
				run_access(rnd[4] | ~rnd[5], next_rand(), rnd[7:6], rnd[5], next_rand(),
					rnd[12:11], pma_pkg::access_e'(acc_bits), rnd[13]);
			end
		end

		$display("checks %0d, mismatches %0d, other failures %0d",
			checks, mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/pma_unit_top.sv */
`default_nettype none

module pma_unit_top (
	input  wire logic                              clk,
	input  wire logic                              rst_n,
	// config port
	input  wire logic                              cfg_cs,
	input  wire logic                              cfg_we,
	input  wire logic [8:0]                        cfg_addr,
	input  wire logic [pma_pkg::cfg_data_bits-1:0] cfg_wdata,
	output      logic [pma_pkg::cfg_data_bits-1:0] cfg_rdata,
	// instruction fetch
	input  wire logic                              if_req,
	input  wire logic [pma_pkg::addr_bits-1:0]     if_addr,
	input  wire logic [1:0]                        if_pl,
	output      logic                              if_busy,
	output      logic                              if_done,
	output      pma_pkg::fault_e                   if_fault,
	output      logic                              if_cacheable,
	output      logic [7:0]                        if_dev_type,
	// data load / store
	input  wire logic                              dc_req,
	input  wire logic [pma_pkg::addr_bits-1:0]     dc_addr,
	input  wire logic [1:0]                        dc_pl,
	input  wire pma_pkg::access_e                  dc_acc,
	output      logic                              dc_busy,
	output      logic                              dc_done,
	output      pma_pkg::fault_e                   dc_fault,
	output      logic                              dc_cacheable,
	output      logic [7:0]                        dc_dev_type
);

	// ============================================================
	// shared lookup port
	// ============================================================
	logic                         if_lk_req, if_lk_gnt;
	logic                         dc_lk_req, dc_lk_gnt;
	logic [pma_pkg::rgn_bits-1:0] if_lk_rgn, dc_lk_rgn;
	logic [pma_pkg::rgn_bits-1:0] lk_rgn;      // granted index into table
	logic [pma_pkg::at_bits-1:0]  lk_at;       // seen by both checkers

	pma_region_table u_table (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg_cs    (cfg_cs),
		.cfg_we    (cfg_we),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg_rdata (cfg_rdata),
		.lk_rgn    (lk_rgn),
		.lk_at     (lk_at)
	);

	// fetch on side a
	pma_lookup_arbiter u_arb (
		.clk   (clk),
		.rst_n (rst_n),
		.req_a (if_lk_req),
		.req_b (dc_lk_req),
		.gnt_a (if_lk_gnt),
		.gnt_b (dc_lk_gnt),
		.rgn_a (if_lk_rgn),
		.rgn_b (dc_lk_rgn),
		.rgn   (lk_rgn)
	);

	// ============================================================
	// checkers
	// ============================================================
	pma_access_checker u_fetch (
		.clk (clk), .rst_n (rst_n),
		.req (if_req), .addr (if_addr), .pl (if_pl),
		.acc (pma_pkg::ACC_EXEC),                  // fetch is always execute
		.busy (if_busy), .done (if_done), .fault (if_fault),
		.cacheable (if_cacheable), .dev_type (if_dev_type),
		.lk_req (if_lk_req), .lk_gnt (if_lk_gnt), .lk_rgn (if_lk_rgn), .lk_at (lk_at)
	);

	pma_access_checker u_data (
		.clk (clk), .rst_n (rst_n),
		.req (dc_req), .addr (dc_addr), .pl (dc_pl), .acc (dc_acc),
		.busy (dc_busy), .done (dc_done), .fault (dc_fault),
		.cacheable (dc_cacheable), .dev_type (dc_dev_type),
		.lk_req (dc_lk_req), .lk_gnt (dc_lk_gnt), .lk_rgn (dc_lk_rgn), .lk_at (lk_at)
	);

endmodule

`default_nettype wire

/* verilog/pma_access_checker.sv */
`default_nettype none

module pma_access_checker (
	input  wire logic                          clk,
	input  wire logic                          rst_n,
	// requester side
	input  wire logic                          req,
	input  wire logic [pma_pkg::addr_bits-1:0] addr,
	input  wire logic [1:0]                    pl,
	input  wire pma_pkg::access_e              acc,
	output      logic                          busy,
	output      logic                          done,
	output      pma_pkg::fault_e               fault,
	output      logic                          cacheable,
	output      logic [7:0]                    dev_type,
	// table lookup side, through the arbiter
	output      logic                          lk_req,
	input  wire logic                          lk_gnt,
	output      logic [pma_pkg::rgn_bits-1:0]  lk_rgn,
	input  wire logic [pma_pkg::at_bits-1:0]   lk_at
);

	pma_pkg::chk_state_e state;

	logic [pma_pkg::rgn_bits-1:0]      rgn_q;      // captured request
	logic [1:0]                        pl_q;
	pma_pkg::access_e                  acc_q;

	logic [pma_pkg::at_entry_bits-1:0] entry;      // at entry for pl_q
	logic [7:0]                        entry_dev;
	logic                              ent_x, ent_w, ent_r, ent_c;
	pma_pkg::fault_e                   fault_d;
	logic                              accept;
	logic                              sample;

	assign accept = (state == pma_pkg::ST_IDLE) & req;     // busy drops req
	assign sample = (state == pma_pkg::ST_LOOKUP) & lk_gnt;

	// ============================================================
	// control FSM
	// ============================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= pma_pkg::ST_IDLE;
		end else begin
			case (state)
			pma_pkg::ST_IDLE:   if (req) state <= pma_pkg::ST_LOOKUP;
			pma_pkg::ST_LOOKUP: if (lk_gnt) state <= pma_pkg::ST_DONE;  // else retry
			pma_pkg::ST_DONE:   state <= pma_pkg::ST_IDLE;    // done is one cycle
			default:            state <= pma_pkg::ST_IDLE;
			endcase
		end
	end

	// request capture, top address bits name the region
	always_ff @(posedge clk) begin
		if (accept) begin
			rgn_q <= addr[pma_pkg::addr_bits-1 -: pma_pkg::rgn_bits];
			pl_q  <= pl;
			acc_q <= acc;
		end
	end

	// ============================================================
	// permission check
	// ============================================================
	assign entry     = lk_at[pl_q*pma_pkg::at_entry_bits +: pma_pkg::at_entry_bits];
	assign entry_dev = entry[15:8];
	assign ent_x     = entry[0];
	assign ent_w     = entry[1];
	assign ent_r     = entry[2];
	assign ent_c     = entry[3];

	always_comb begin
		fault_d = pma_pkg::FAULT_NONE;
		if (entry_dev == pma_pkg::dev_none) begin
			fault_d = pma_pkg::FAULT_NO_ACCESS;      // vacant beats rwx
		end else begin
			case (acc_q)
			pma_pkg::ACC_READ:  if (!ent_r) fault_d = pma_pkg::FAULT_NO_READ;
			pma_pkg::ACC_WRITE: if (!ent_w) fault_d = pma_pkg::FAULT_NO_WRITE;
			pma_pkg::ACC_EXEC:  if (!ent_x) fault_d = pma_pkg::FAULT_NO_EXEC;
			default:            fault_d = pma_pkg::FAULT_NONE;
			endcase
		end
	end

	// result held from the grant cycle, valid alongside done
	always_ff @(posedge clk) begin
		if (sample) begin
			fault     <= fault_d;
			cacheable <= ent_c;
			dev_type  <= entry_dev;
		end
	end

	// ============================================================
	// outputs
	// ============================================================
	assign busy   = (state != pma_pkg::ST_IDLE);
	assign done   = (state == pma_pkg::ST_DONE);
	assign lk_req = (state == pma_pkg::ST_LOOKUP);   // held until granted
	assign lk_rgn = rgn_q;

endmodule

`default_nettype wire

/* verilog/pma_lookup_arbiter.sv */
`default_nettype none

module pma_lookup_arbiter (
	input  wire logic                         clk,
	input  wire logic                         rst_n,
	input  wire logic                         req_a,    // fetch checker
	input  wire logic                         req_b,    // data checker
	output      logic                         gnt_a,
	output      logic                         gnt_b,
	input  wire logic [pma_pkg::rgn_bits-1:0] rgn_a,
	input  wire logic [pma_pkg::rgn_bits-1:0] rgn_b,
	output      logic [pma_pkg::rgn_bits-1:0] rgn       // to table lookup index
);

	// ============================================================
	// priority pointer
	// ============================================================
	// low favors a, high favors b
	logic prio_b;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prio_b <= 1'b0;
		end else begin
			// hand priority over after every grant
			if (gnt_a)
				prio_b <= 1'b1;
			else if (gnt_b)
				prio_b <= 1'b0;
		end
	end

	// ============================================================
	// grant
	// ============================================================
	// lone requester wins outright, pointer only breaks ties
	always_comb begin
		gnt_a = 1'b0;
		gnt_b = 1'b0;
		if (req_a && req_b) begin
			gnt_a = ~prio_b;
			gnt_b = prio_b;
		end else begin
			gnt_a = req_a;
			gnt_b = req_b;
		end
	end

	// forward the winner's region, a by default when idle
	assign rgn = gnt_b ? rgn_b : rgn_a;

endmodule

`default_nettype wire

/* verilog/pma_region_table.sv */
`default_nettype none

module pma_region_table (
	input  wire logic                              clk,
	input  wire logic                              rst_n,
	// config port
	input  wire logic                              cfg_cs,
	input  wire logic                              cfg_we,
	input  wire logic [8:0]                        cfg_addr,
	input  wire logic [pma_pkg::cfg_data_bits-1:0] cfg_wdata,
	output      logic [pma_pkg::cfg_data_bits-1:0] cfg_rdata,
	// lookup port
	input  wire logic [pma_pkg::rgn_bits-1:0]      lk_rgn,
	output      logic [pma_pkg::at_bits-1:0]       lk_at
);

	// ============================================================
	// region storage
	// ============================================================
	logic [pma_pkg::addr_bits-1:0] pmt  [pma_pkg::num_regions];
	logic [pma_pkg::addr_bits-1:0] cta  [pma_pkg::num_regions];
	logic [pma_pkg::at_bits-1:0]   at   [pma_pkg::num_regions];
	logic [31:0]                   lock [pma_pkg::num_regions];

	// config address decode
	logic [pma_pkg::rgn_bits-1:0] cfg_rgn;
	pma_pkg::pma_field_e          cfg_field;
	logic                         cfg_wr;
	logic                         rgn_unlocked;

	assign cfg_rgn      = cfg_addr[8:6];                          // region select
	assign cfg_field    = pma_pkg::pma_field_e'(cfg_addr[5:4]);   // register within region
	assign cfg_wr       = cfg_cs & cfg_we;
	assign rgn_unlocked = (lock[cfg_rgn] == pma_pkg::unlock_word);

	// ============================================================
	// guarded writes
	// ============================================================
	// table comes up with the fixed memory map, every region locked
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < pma_pkg::num_regions; i++) begin
				pmt[i]  <= pma_pkg::reset_pmt(i[pma_pkg::rgn_bits-1:0]);
				cta[i]  <= '0;
				at[i]   <= pma_pkg::reset_at(i[pma_pkg::rgn_bits-1:0]);
				lock[i] <= pma_pkg::lock_word;
			end
		end else if (cfg_wr) begin
			case (cfg_field)
			pma_pkg::FIELD_PMT: begin
				if (rgn_unlocked)
					pmt[cfg_rgn] <= cfg_wdata[pma_pkg::addr_bits-1:0];  // low word only
			end
			pma_pkg::FIELD_CTA: begin
				if (rgn_unlocked)
					cta[cfg_rgn] <= cfg_wdata[pma_pkg::addr_bits-1:0];
			end
			pma_pkg::FIELD_AT: begin
				if (rgn_unlocked)
					at[cfg_rgn] <= cfg_wdata;
			end
			pma_pkg::FIELD_LOCK: begin
				// lock word itself always writable, else a region could never reopen
				lock[cfg_rgn] <= cfg_wdata[31:0];
			end
			default: ;
			endcase
		end
	end

	// ============================================================
	// registered readback
	// ============================================================
	logic [pma_pkg::cfg_data_bits-1:0] rd_mux;

	always_comb begin
		rd_mux = '0;
		case (cfg_field)
		pma_pkg::FIELD_PMT:  rd_mux = {{(pma_pkg::cfg_data_bits-pma_pkg::addr_bits){1'b0}},
			pmt[cfg_rgn]};
		pma_pkg::FIELD_CTA:  rd_mux = {{(pma_pkg::cfg_data_bits-pma_pkg::addr_bits){1'b0}},
			cta[cfg_rgn]};
		pma_pkg::FIELD_AT:   rd_mux = at[cfg_rgn];
		pma_pkg::FIELD_LOCK: rd_mux = {32'h0, lock[cfg_rgn]};
		default:             rd_mux = '0;
		endcase
	end

	// old value on a same-cycle write, new one shows a cycle later
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cfg_rdata <= '0;
		else if (cfg_cs)
			cfg_rdata <= rd_mux;
		else
			cfg_rdata <= '0;     // idle bus reads back zero
	end

	// ============================================================
	// lookup
	// ============================================================
	// combinational, the checker samples it in its grant cycle
	assign lk_at = at[lk_rgn];

endmodule

`default_nettype wire

/* verilog/pma_pkg.sv */
`default_nettype none

package pma_pkg;

	// ============================================================
	// sizes
	// ============================================================
	localparam int num_regions   = 8;
	localparam int rgn_bits      = 3;    // region index
	localparam int addr_bits     = 32;   // also pmt / cta width
	localparam int cfg_data_bits = 64;
	localparam int num_pl        = 4;    // privilege levels, one at entry each

	localparam int at_entry_bits = 16;   // dev_type[15:8], rwx[3:0]
	localparam int at_bits       = at_entry_bits * num_pl;

	localparam logic [31:0] lock_word   = "LOCK";
	localparam logic [31:0] unlock_word = "UNLK";
	localparam logic [7:0]  dev_none    = 8'hFF;   // vacant region, no access

	// ============================================================
	// enums
	// ============================================================
	typedef enum logic [1:0] {FIELD_PMT, FIELD_CTA, FIELD_AT, FIELD_LOCK} pma_field_e;

	typedef enum logic [1:0] {ACC_READ, ACC_WRITE, ACC_EXEC} access_e;

	typedef enum logic [2:0] {
		FAULT_NONE,
		FAULT_NO_ACCESS,
		FAULT_NO_READ,
		FAULT_NO_WRITE,
		FAULT_NO_EXEC
	} fault_e;

	typedef enum logic [1:0] {ST_IDLE, ST_LOOKUP, ST_DONE} chk_state_e;

	// ============================================================
	// reset table contents
	// ============================================================
	function automatic logic [at_bits-1:0] reset_at(input logic [rgn_bits-1:0] rgn);
		logic [3:0] rwx;
		logic [7:0] dev;
		rwx = 4'h0;
		dev = 8'h00;
		case (rgn)
		3'd7:    rwx = 4'hD;          // rom, cache read exec
		3'd6:    rwx = 4'h6;          // io, read write
		3'd5:    rwx = 4'h6;          // config space
		3'd4:    rwx = 4'hF;          // scratchpad
		3'd1: begin                   // dram
			rwx = 4'hF;
			dev = 8'h01;
		end
		default: dev = dev_none;      // 0, 2 and 3 vacant
		endcase
		return {num_pl{dev, 4'h0, rwx}};   // same entry for every pl
	endfunction

	function automatic logic [addr_bits-1:0] reset_pmt(input logic [rgn_bits-1:0] rgn);
		case (rgn)
		3'd6:    return 32'h0000_0300;
		3'd4:    return 32'h0000_2300;
		3'd1:    return 32'h0000_2400;
		default: return '0;
		endcase
	endfunction

endpackage

`default_nettype wire
